// File: common/mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int INSTR_W    = 32;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;
	localparam int TARGET_W   = INSTR_W - OPCODE_W;    // 26 bit jump target

	localparam logic [OPCODE_W-1:0] OPCODE_RTYPE = 6'h00;
	localparam logic [OPCODE_W-1:0] OPCODE_J     = 6'h02;
	localparam logic [OPCODE_W-1:0] OPCODE_JAL   = 6'h03;

	localparam logic [FUNCT_W-1:0] FUNCT_SLL  = 6'h00;
	localparam logic [FUNCT_W-1:0] FUNCT_SRL  = 6'h02;
	localparam logic [FUNCT_W-1:0] FUNCT_SRA  = 6'h03;
	localparam logic [FUNCT_W-1:0] FUNCT_SLLV = 6'h04;
	localparam logic [FUNCT_W-1:0] FUNCT_XCH  = 6'h05;    // custom swap of rs and rt
	localparam logic [FUNCT_W-1:0] FUNCT_SRAV = 6'h07;
	localparam logic [FUNCT_W-1:0] FUNCT_JR   = 6'h08;
	localparam logic [FUNCT_W-1:0] FUNCT_MFHI = 6'h10;
	localparam logic [FUNCT_W-1:0] FUNCT_MFLO = 6'h12;
	localparam logic [FUNCT_W-1:0] FUNCT_MULT = 6'h18;
	localparam logic [FUNCT_W-1:0] FUNCT_DIV  = 6'h1a;
	localparam logic [FUNCT_W-1:0] FUNCT_ADD  = 6'h20;
	localparam logic [FUNCT_W-1:0] FUNCT_SUB  = 6'h22;
	localparam logic [FUNCT_W-1:0] FUNCT_AND  = 6'h24;
	localparam logic [FUNCT_W-1:0] FUNCT_SLT  = 6'h2a;

	// one IR word, seen as R format or as J format
	typedef union packed {
		struct packed {
			logic [OPCODE_W-1:0]   opcode;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [REG_ADDR_W-1:0] rd;
			logic [SHAMT_W-1:0]    shamt;
			logic [FUNCT_W-1:0]    funct;
		} r;
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [TARGET_W-1:0] target;    // word index inside the current region
		} j;
	} instr_word_t;

endpackage

// File: common/ctrl_pkg.sv
package ctrl_pkg;

	localparam int STATE_W = 8;
	localparam int COUNT_W = 6;

	localparam logic [STATE_W-1:0] ST_RESET        = 8'h00;
	localparam logic [STATE_W-1:0] ST_FETCH        = 8'h01;
	localparam logic [STATE_W-1:0] ST_FETCH_2      = 8'h02;
	localparam logic [STATE_W-1:0] ST_DECODE       = 8'h03;
	localparam logic [STATE_W-1:0] ST_ALU_EXEC     = 8'h04;    // add, and, sub
	localparam logic [STATE_W-1:0] ST_SHIFT_LOAD   = 8'h07;
	localparam logic [STATE_W-1:0] ST_MOVE_HILO    = 8'h0c;
	localparam logic [STATE_W-1:0] ST_SLT          = 8'h0e;
	localparam logic [STATE_W-1:0] ST_JR           = 8'h0f;
	localparam logic [STATE_W-1:0] ST_MULDIV_START = 8'h12;
	localparam logic [STATE_W-1:0] ST_XCH_1        = 8'h14;
	localparam logic [STATE_W-1:0] ST_JUMP         = 8'h15;    // shared by j and jal
	localparam logic [STATE_W-1:0] ST_JAL_LINK     = 8'h16;
	localparam logic [STATE_W-1:0] ST_XCH_2        = 8'h17;
	localparam logic [STATE_W-1:0] ST_MULDIV_WAIT  = 8'h1d;
	localparam logic [STATE_W-1:0] ST_WRITE_ARITH  = 8'h85;
	localparam logic [STATE_W-1:0] ST_SHIFT_RUN    = 8'h86;
	localparam logic [STATE_W-1:0] ST_SHIFT_WRITE  = 8'h87;
	localparam logic [STATE_W-1:0] ST_FINAL        = 8'hff;

	typedef enum logic [4:0] {
		OP_NONE,
		OP_ADD, OP_AND, OP_SUB, OP_SLT,
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRAV,
		OP_MULT, OP_DIV, OP_MFHI, OP_MFLO,
		OP_JR, OP_J, OP_JAL, OP_XCH
	} op_class_t;

	// cycles spent in ST_FETCH and ST_MULDIV_WAIT
	localparam logic [COUNT_W-1:0] FETCH_WAIT_CYCLES  = 6'd2;
	localparam logic [COUNT_W-1:0] MULDIV_WAIT_CYCLES = 6'd34;

	localparam int ALU_SRC_A_W  = 2;
	localparam int ALU_SRC_B_W  = 3;
	localparam int PC_SRC_W     = 3;
	localparam int REG_DST_W    = 3;
	localparam int MEM_TO_REG_W = 4;
	localparam int ALU_OP_W     = 3;
	localparam int SHIFT_OP_W   = 3;

	localparam logic [ALU_OP_W-1:0] ALU_LOAD = 3'd0;    // pass operand a
	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_CMP  = 3'd7;

	localparam logic [ALU_SRC_A_W-1:0] SRC_A_PC    = 2'd0;
	localparam logic [ALU_SRC_A_W-1:0] SRC_A_REG_A = 2'd2;

	localparam logic [ALU_SRC_B_W-1:0] SRC_B_REG_B  = 3'd0;
	localparam logic [ALU_SRC_B_W-1:0] SRC_B_FOUR   = 3'd1;
	localparam logic [ALU_SRC_B_W-1:0] SRC_B_OFFSET = 3'd4;    // sign extended, shifted imm

	localparam logic [PC_SRC_W-1:0] PC_SRC_ALU  = 3'd0;
	localparam logic [PC_SRC_W-1:0] PC_SRC_JUMP = 3'd3;

	localparam logic [REG_DST_W-1:0] DST_RT = 3'd0;
	localparam logic [REG_DST_W-1:0] DST_RS = 3'd1;
	localparam logic [REG_DST_W-1:0] DST_RD = 3'd2;
	localparam logic [REG_DST_W-1:0] DST_SP = 3'd3;
	localparam logic [REG_DST_W-1:0] DST_RA = 3'd4;

	localparam logic [MEM_TO_REG_W-1:0] WB_ALU_OUT = 4'd0;
	localparam logic [MEM_TO_REG_W-1:0] WB_HI      = 4'd2;
	localparam logic [MEM_TO_REG_W-1:0] WB_LO      = 4'd3;
	localparam logic [MEM_TO_REG_W-1:0] WB_SHIFT   = 4'd6;
	localparam logic [MEM_TO_REG_W-1:0] WB_SP_INIT = 4'd7;    // top of stack constant
	localparam logic [MEM_TO_REG_W-1:0] WB_XCH     = 4'd8;
	localparam logic [MEM_TO_REG_W-1:0] WB_LT      = 4'd9;
	localparam logic [MEM_TO_REG_W-1:0] WB_RT      = 4'd10;

	localparam logic [SHIFT_OP_W-1:0] SHIFT_NOP         = 3'd0;
	localparam logic [SHIFT_OP_W-1:0] SHIFT_LOAD_IMM    = 3'd1;
	localparam logic [SHIFT_OP_W-1:0] SHIFT_LEFT        = 3'd2;
	localparam logic [SHIFT_OP_W-1:0] SHIFT_RIGHT_LOGIC = 3'd3;
	localparam logic [SHIFT_OP_W-1:0] SHIFT_RIGHT_ARITH = 3'd4;
	localparam logic [SHIFT_OP_W-1:0] SHIFT_LOAD_VAR    = 3'd5;

endpackage

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  mips_isa_pkg::instr_word_t instr,
	output ctrl_pkg::op_class_t       op_class
);

	always_comb begin
		op_class = ctrl_pkg::OP_NONE;
		case (instr.j.opcode)
			mips_isa_pkg::OPCODE_RTYPE: begin
				case (instr.r.funct)
					mips_isa_pkg::FUNCT_ADD:  op_class = ctrl_pkg::OP_ADD;
					mips_isa_pkg::FUNCT_AND:  op_class = ctrl_pkg::OP_AND;
					mips_isa_pkg::FUNCT_SUB:  op_class = ctrl_pkg::OP_SUB;
					mips_isa_pkg::FUNCT_SLT:  op_class = ctrl_pkg::OP_SLT;
					mips_isa_pkg::FUNCT_SLL:  op_class = ctrl_pkg::OP_SLL;
					mips_isa_pkg::FUNCT_SRL:  op_class = ctrl_pkg::OP_SRL;
					mips_isa_pkg::FUNCT_SRA:  op_class = ctrl_pkg::OP_SRA;
					mips_isa_pkg::FUNCT_SLLV: op_class = ctrl_pkg::OP_SLLV;
					mips_isa_pkg::FUNCT_SRAV: op_class = ctrl_pkg::OP_SRAV;
					mips_isa_pkg::FUNCT_MULT: op_class = ctrl_pkg::OP_MULT;
					mips_isa_pkg::FUNCT_DIV:  op_class = ctrl_pkg::OP_DIV;
					mips_isa_pkg::FUNCT_MFHI: op_class = ctrl_pkg::OP_MFHI;
					mips_isa_pkg::FUNCT_MFLO: op_class = ctrl_pkg::OP_MFLO;
					mips_isa_pkg::FUNCT_JR:   op_class = ctrl_pkg::OP_JR;
					mips_isa_pkg::FUNCT_XCH:  op_class = ctrl_pkg::OP_XCH;
					default:                  op_class = ctrl_pkg::OP_NONE;    // runs as a no-op
				endcase
			end
			mips_isa_pkg::OPCODE_J:   op_class = ctrl_pkg::OP_J;    // target needs no funct
			mips_isa_pkg::OPCODE_JAL: op_class = ctrl_pkg::OP_JAL;
			default:                  op_class = ctrl_pkg::OP_NONE;
		endcase
	end

endmodule

// File: control_fsm/state_sequencer.sv
`timescale 1ns/1ps

module state_sequencer (
	input  logic                         clock,
	input  logic                         reset,
	input  ctrl_pkg::op_class_t          op_class,
	output logic [ctrl_pkg::STATE_W-1:0] state,
	output logic                         wait_done
);

	logic [ctrl_pkg::STATE_W-1:0] state_next;
	logic [ctrl_pkg::COUNT_W-1:0] count;

	// high in the last cycle of a timed wait
	always_comb begin
		case (state)
			ctrl_pkg::ST_FETCH:
				wait_done = (count == ctrl_pkg::FETCH_WAIT_CYCLES - 1'b1);
			ctrl_pkg::ST_MULDIV_WAIT:
				wait_done = (count == ctrl_pkg::MULDIV_WAIT_CYCLES - 1'b1);
			default:
				wait_done = 1'b0;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			ctrl_pkg::ST_RESET:   state_next = ctrl_pkg::ST_FETCH;
			ctrl_pkg::ST_FETCH: begin
				if (wait_done) begin
					state_next = ctrl_pkg::ST_FETCH_2;    // memory read settled
				end
			end
			ctrl_pkg::ST_FETCH_2: state_next = ctrl_pkg::ST_DECODE;
			ctrl_pkg::ST_DECODE: begin
				case (op_class)
					ctrl_pkg::OP_ADD,
					ctrl_pkg::OP_AND,
					ctrl_pkg::OP_SUB:  state_next = ctrl_pkg::ST_ALU_EXEC;
					ctrl_pkg::OP_SLL,
					ctrl_pkg::OP_SRL,
					ctrl_pkg::OP_SRA,
					ctrl_pkg::OP_SLLV,
					ctrl_pkg::OP_SRAV: state_next = ctrl_pkg::ST_SHIFT_LOAD;
					ctrl_pkg::OP_MULT,
					ctrl_pkg::OP_DIV:  state_next = ctrl_pkg::ST_MULDIV_START;
					ctrl_pkg::OP_MFHI,
					ctrl_pkg::OP_MFLO: state_next = ctrl_pkg::ST_MOVE_HILO;
					ctrl_pkg::OP_SLT:  state_next = ctrl_pkg::ST_SLT;
					ctrl_pkg::OP_JR:   state_next = ctrl_pkg::ST_JR;
					ctrl_pkg::OP_J:    state_next = ctrl_pkg::ST_JUMP;
					ctrl_pkg::OP_JAL:  state_next = ctrl_pkg::ST_JAL_LINK;
					ctrl_pkg::OP_XCH:  state_next = ctrl_pkg::ST_XCH_1;
					default:           state_next = ctrl_pkg::ST_FINAL;    // undecoded word
				endcase
			end
			ctrl_pkg::ST_ALU_EXEC:     state_next = ctrl_pkg::ST_WRITE_ARITH;
			ctrl_pkg::ST_SHIFT_LOAD:   state_next = ctrl_pkg::ST_SHIFT_RUN;
			ctrl_pkg::ST_SHIFT_RUN:    state_next = ctrl_pkg::ST_SHIFT_WRITE;
			ctrl_pkg::ST_MULDIV_START: state_next = ctrl_pkg::ST_MULDIV_WAIT;
			ctrl_pkg::ST_MULDIV_WAIT: begin
				if (wait_done) begin
					state_next = ctrl_pkg::ST_FINAL;
				end
			end
			ctrl_pkg::ST_JAL_LINK:     state_next = ctrl_pkg::ST_JUMP;    // link, then jump
			ctrl_pkg::ST_XCH_1:        state_next = ctrl_pkg::ST_XCH_2;
			ctrl_pkg::ST_WRITE_ARITH,
			ctrl_pkg::ST_SHIFT_WRITE,
			ctrl_pkg::ST_MOVE_HILO,
			ctrl_pkg::ST_SLT,
			ctrl_pkg::ST_JR,
			ctrl_pkg::ST_JUMP,
			ctrl_pkg::ST_XCH_2:        state_next = ctrl_pkg::ST_FINAL;
			ctrl_pkg::ST_FINAL:        state_next = ctrl_pkg::ST_FETCH;
			default:                   state_next = ctrl_pkg::ST_FINAL;    // stray code recovers
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ctrl_pkg::ST_RESET;
			count <= '0;
		end else begin
			state <= state_next;
			if (state_next != state) begin
				count <= '0;    // fresh count on every state change
			end else begin
				count <= count + 1'b1;    // only the two wait states loop on themselves
			end
		end
	end

endmodule

// File: control_fsm/datapath_ctrl_gen.sv
`timescale 1ns/1ps

module datapath_ctrl_gen (
	input  logic [ctrl_pkg::STATE_W-1:0]      state,
	input  ctrl_pkg::op_class_t               op_class,
	input  logic                              wait_done,
	output logic                              pc_write,
	output logic                              ir_write,
	output logic                              reg_write,
	output logic                              alu_out_load,
	output logic                              a_b_load,
	output logic                              xch_load,
	output logic                              hi_lo_load,
	output logic                              mult_start,
	output logic                              div_start,
	output logic                              shift_amt_from_rs,
	output logic [ctrl_pkg::ALU_OP_W-1:0]     alu_op,
	output logic [ctrl_pkg::ALU_SRC_A_W-1:0]  alu_src_a,
	output logic [ctrl_pkg::ALU_SRC_B_W-1:0]  alu_src_b,
	output logic [ctrl_pkg::PC_SRC_W-1:0]     pc_source,
	output logic [ctrl_pkg::REG_DST_W-1:0]    reg_dst,
	output logic [ctrl_pkg::MEM_TO_REG_W-1:0] mem_to_reg,
	output logic [ctrl_pkg::SHIFT_OP_W-1:0]   shift_op
);

	logic var_shift;

	assign var_shift = (op_class == ctrl_pkg::OP_SLLV) || (op_class == ctrl_pkg::OP_SRAV);

	always_comb begin
		pc_write          = 1'b0;
		ir_write          = 1'b0;
		reg_write         = 1'b0;
		alu_out_load      = 1'b0;
		a_b_load          = 1'b0;
		xch_load          = 1'b0;
		hi_lo_load        = 1'b0;
		mult_start        = 1'b0;
		div_start         = 1'b0;
		shift_amt_from_rs = 1'b0;
		alu_op            = ctrl_pkg::ALU_LOAD;
		alu_src_a         = ctrl_pkg::SRC_A_PC;
		alu_src_b         = ctrl_pkg::SRC_B_REG_B;
		pc_source         = ctrl_pkg::PC_SRC_ALU;
		reg_dst           = ctrl_pkg::DST_RT;
		mem_to_reg        = ctrl_pkg::WB_ALU_OUT;
		shift_op          = ctrl_pkg::SHIFT_NOP;

		case (state)
			ctrl_pkg::ST_RESET: begin
				reg_write  = 1'b1;    // sp gets the stack top
				reg_dst    = ctrl_pkg::DST_SP;
				mem_to_reg = ctrl_pkg::WB_SP_INIT;
			end
			ctrl_pkg::ST_FETCH: begin
				ir_write  = 1'b1;
				alu_op    = ctrl_pkg::ALU_ADD;    // pc + 4
				alu_src_b = ctrl_pkg::SRC_B_FOUR;
			end
			ctrl_pkg::ST_FETCH_2: begin
				pc_write  = 1'b1;
				alu_op    = ctrl_pkg::ALU_ADD;
				alu_src_b = ctrl_pkg::SRC_B_FOUR;
			end
			ctrl_pkg::ST_DECODE: begin
				a_b_load     = 1'b1;
				xch_load     = 1'b1;    // keep a copy of rs for xch
				alu_out_load = 1'b1;
				alu_op       = ctrl_pkg::ALU_ADD;
				alu_src_b    = ctrl_pkg::SRC_B_OFFSET;
			end
			ctrl_pkg::ST_ALU_EXEC: begin
				alu_out_load = 1'b1;
				alu_src_a    = ctrl_pkg::SRC_A_REG_A;
				case (op_class)
					ctrl_pkg::OP_AND: alu_op = ctrl_pkg::ALU_AND;
					ctrl_pkg::OP_SUB: alu_op = ctrl_pkg::ALU_SUB;
					default:          alu_op = ctrl_pkg::ALU_ADD;
				endcase
			end
			ctrl_pkg::ST_WRITE_ARITH: begin
				reg_write = 1'b1;
				reg_dst   = ctrl_pkg::DST_RD;
			end
			ctrl_pkg::ST_SHIFT_LOAD: begin
				shift_amt_from_rs = var_shift;
				shift_op = var_shift ? ctrl_pkg::SHIFT_LOAD_VAR : ctrl_pkg::SHIFT_LOAD_IMM;
			end
			ctrl_pkg::ST_SHIFT_RUN: begin
				shift_amt_from_rs = var_shift;
				case (op_class)
					ctrl_pkg::OP_SRL:  shift_op = ctrl_pkg::SHIFT_RIGHT_LOGIC;
					ctrl_pkg::OP_SRA,
					ctrl_pkg::OP_SRAV: shift_op = ctrl_pkg::SHIFT_RIGHT_ARITH;
					default:           shift_op = ctrl_pkg::SHIFT_LEFT;    // sll, sllv
				endcase
			end
			ctrl_pkg::ST_SHIFT_WRITE: begin
				reg_write  = 1'b1;
				reg_dst    = ctrl_pkg::DST_RD;
				mem_to_reg = ctrl_pkg::WB_SHIFT;
			end
			ctrl_pkg::ST_MULDIV_START: begin
				mult_start = (op_class == ctrl_pkg::OP_MULT);
				div_start  = (op_class == ctrl_pkg::OP_DIV);
			end
			ctrl_pkg::ST_MULDIV_WAIT: begin
				hi_lo_load = wait_done;    // result valid after the fixed wait
			end
			ctrl_pkg::ST_MOVE_HILO: begin
				reg_write  = 1'b1;
				reg_dst    = ctrl_pkg::DST_RD;
				mem_to_reg = (op_class == ctrl_pkg::OP_MFLO) ? ctrl_pkg::WB_LO : ctrl_pkg::WB_HI;
			end
			ctrl_pkg::ST_SLT: begin
				reg_write  = 1'b1;
				reg_dst    = ctrl_pkg::DST_RD;
				mem_to_reg = ctrl_pkg::WB_LT;    // lt flag, zero extended
				alu_op     = ctrl_pkg::ALU_CMP;
				alu_src_a  = ctrl_pkg::SRC_A_REG_A;
			end
			ctrl_pkg::ST_JR: begin
				pc_write  = 1'b1;
				alu_src_a = ctrl_pkg::SRC_A_REG_A;    // alu passes rs through
			end
			ctrl_pkg::ST_JUMP: begin
				pc_write  = 1'b1;
				pc_source = ctrl_pkg::PC_SRC_JUMP;
			end
			ctrl_pkg::ST_JAL_LINK: begin
				alu_out_load = 1'b1;
				reg_write    = 1'b1;
				reg_dst      = ctrl_pkg::DST_RA;
			end
			ctrl_pkg::ST_XCH_1: begin
				reg_write  = 1'b1;    // rs <= rt
				reg_dst    = ctrl_pkg::DST_RS;
				mem_to_reg = ctrl_pkg::WB_RT;
			end
			ctrl_pkg::ST_XCH_2: begin
				reg_write  = 1'b1;    // rt <= old rs
				reg_dst    = ctrl_pkg::DST_RT;
				mem_to_reg = ctrl_pkg::WB_XCH;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: src/multicycle_control.sv
`timescale 1ns/1ps

module multicycle_control (
	input  logic                              clock,
	input  logic                              reset,
	input  mips_isa_pkg::instr_word_t         instr,
	output logic [ctrl_pkg::STATE_W-1:0]      state,
	output logic                              pc_write,
	output logic                              ir_write,
	output logic                              reg_write,
	output logic                              alu_out_load,
	output logic                              a_b_load,
	output logic                              xch_load,
	output logic                              hi_lo_load,
	output logic                              mult_start,
	output logic                              div_start,
	output logic                              shift_amt_from_rs,
	output logic [ctrl_pkg::ALU_OP_W-1:0]     alu_op,
	output logic [ctrl_pkg::ALU_SRC_A_W-1:0]  alu_src_a,
	output logic [ctrl_pkg::ALU_SRC_B_W-1:0]  alu_src_b,
	output logic [ctrl_pkg::PC_SRC_W-1:0]     pc_source,
	output logic [ctrl_pkg::REG_DST_W-1:0]    reg_dst,
	output logic [ctrl_pkg::MEM_TO_REG_W-1:0] mem_to_reg,
	output logic [ctrl_pkg::SHIFT_OP_W-1:0]   shift_op
);

	ctrl_pkg::op_class_t op_class;
	logic                wait_done;

	instr_decoder u_decoder (
		.instr    (instr),
		.op_class (op_class)
	);

	state_sequencer u_sequencer (
		.clock     (clock),
		.reset     (reset),
		.op_class  (op_class),
		.state     (state),
		.wait_done (wait_done)
	);

	datapath_ctrl_gen u_ctrl_gen (
		.state             (state),
		.op_class          (op_class),
		.wait_done         (wait_done),
		.pc_write          (pc_write),
		.ir_write          (ir_write),
		.reg_write         (reg_write),
		.alu_out_load      (alu_out_load),
		.a_b_load          (a_b_load),
		.xch_load          (xch_load),
		.hi_lo_load        (hi_lo_load),
		.mult_start        (mult_start),
		.div_start         (div_start),
		.shift_amt_from_rs (shift_amt_from_rs),
		.alu_op            (alu_op),
		.alu_src_a         (alu_src_a),
		.alu_src_b         (alu_src_b),
		.pc_source         (pc_source),
		.reg_dst           (reg_dst),
		.mem_to_reg        (mem_to_reg),
		.shift_op          (shift_op)
	);

endmodule

// File: test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_ROWS = 19;

string       row_name      [NUM_ROWS];
logic [31:0] row_word      [NUM_ROWS];
int          row_cycles    [NUM_ROWS];    // fetch entry to fetch entry
int          row_n_write   [NUM_ROWS];
int          row_n_pc      [NUM_ROWS];
int          row_exec_alu  [NUM_ROWS];    // alu_op in the first cycle after decode
int          row_first_dst [NUM_ROWS];    // -1 when no register write
int          row_first_wb  [NUM_ROWS];
int          row_last_dst  [NUM_ROWS];
int          row_last_wb   [NUM_ROWS];
int          row_run_shift [NUM_ROWS];
int          row_n_amt     [NUM_ROWS];
int          row_n_mult    [NUM_ROWS];
int          row_n_div     [NUM_ROWS];
int          row_n_hilo    [NUM_ROWS];
int          row_pc_src    [NUM_ROWS];    // pc_source at the last pc_write
int          row_fill;

task automatic add_row(input string name, input logic [31:0] word, input int cycles,
		input int n_write, input int n_pc, input int exec_alu, input int first_dst,
		input int first_wb, input int last_dst, input int last_wb, input int run_shift,
		input int n_amt, input int n_mult, input int n_div, input int n_hilo,
		input int pc_src);
	row_name[row_fill]      = name;
	row_word[row_fill]      = word;
	row_cycles[row_fill]    = cycles;
	row_n_write[row_fill]   = n_write;
	row_n_pc[row_fill]      = n_pc;
	row_exec_alu[row_fill]  = exec_alu;
	row_first_dst[row_fill] = first_dst;
	row_first_wb[row_fill]  = first_wb;
	row_last_dst[row_fill]  = last_dst;
	row_last_wb[row_fill]   = last_wb;
	row_run_shift[row_fill] = run_shift;
	row_n_amt[row_fill]     = n_amt;
	row_n_mult[row_fill]    = n_mult;
	row_n_div[row_fill]     = n_div;
	row_n_hilo[row_fill]    = n_hilo;
	row_pc_src[row_fill]    = pc_src;
	row_fill++;
endtask

// name, word, cycles, writes, pc writes, exec alu, first dst, first wb, last dst,
// last wb, run shift, amt cycles, mult, div, hilo, pc source
task automatic load_vectors();
	row_fill = 0;
	add_row("add",  r_word(6'h20), 7, 1, 1, 1, 2, 0, 2, 0, 0, 0, 0, 0, 0, 0);
	add_row("and",  r_word(6'h24), 7, 1, 1, 3, 2, 0, 2, 0, 0, 0, 0, 0, 0, 0);
	add_row("sub",  r_word(6'h22), 7, 1, 1, 2, 2, 0, 2, 0, 0, 0, 0, 0, 0, 0);
	add_row("slt",  r_word(6'h2a), 6, 1, 1, 7, 2, 9, 2, 9, 0, 0, 0, 0, 0, 0);
	add_row("sll",  r_word(6'h00), 8, 1, 1, 0, 2, 6, 2, 6, 2, 0, 0, 0, 0, 0);
	add_row("srl",  r_word(6'h02), 8, 1, 1, 0, 2, 6, 2, 6, 3, 0, 0, 0, 0, 0);
	add_row("sra",  r_word(6'h03), 8, 1, 1, 0, 2, 6, 2, 6, 4, 0, 0, 0, 0, 0);
	add_row("sllv", r_word(6'h04), 8, 1, 1, 0, 2, 6, 2, 6, 2, 2, 0, 0, 0, 0);
	add_row("srav", r_word(6'h07), 8, 1, 1, 0, 2, 6, 2, 6, 4, 2, 0, 0, 0, 0);
	add_row("mult", r_word(6'h18), 40, 0, 1, 0, -1, -1, -1, -1, 0, 0, 1, 0, 1, 0);
	add_row("mfhi", r_word(6'h10), 6, 1, 1, 0, 2, 2, 2, 2, 0, 0, 0, 0, 0, 0);
	add_row("div",  r_word(6'h1a), 40, 0, 1, 0, -1, -1, -1, -1, 0, 0, 0, 1, 1, 0);
	add_row("mflo", r_word(6'h12), 6, 1, 1, 0, 2, 3, 2, 3, 0, 0, 0, 0, 0, 0);
	add_row("jr",   r_word(6'h08), 6, 0, 2, 0, -1, -1, -1, -1, 0, 0, 0, 0, 0, 0);
	add_row("j",    j_word(6'h02), 6, 0, 2, 0, -1, -1, -1, -1, 0, 0, 0, 0, 0, 3);
	add_row("jal",  j_word(6'h03), 7, 1, 2, 0, 4, 0, 4, 0, 0, 0, 0, 0, 0, 3);
	add_row("xch",  r_word(6'h05), 7, 2, 1, 0, 1, 10, 0, 8, 0, 0, 0, 0, 0, 0);
	add_row("bad funct",  r_word(6'h3f), 5, 0, 1, 0, -1, -1, -1, -1, 0, 0, 0, 0, 0, 0);
	add_row("bad opcode", j_word(6'h23), 5, 0, 1, 0, -1, -1, -1, -1, 0, 0, 0, 0, 0, 0);
endtask

`endif

// File: test/tb_multicycle_control.sv
`timescale 1ns/1ps

module tb_multicycle_control;

	logic        clock;
	logic        reset;
	logic [31:0] instr;

	logic [7:0] state;
	logic       pc_write, ir_write, reg_write, alu_out_load, a_b_load, xch_load;
	logic       hi_lo_load, mult_start, div_start, shift_amt_from_rs;
	logic [2:0] alu_op, alu_src_b, pc_source, reg_dst, shift_op;
	logic [1:0] alu_src_a;
	logic [3:0] mem_to_reg;

	integer seed = 20;
	int     cycle_count = 0;
	int     cycle_limit = 0;

	multicycle_control u_dut (
		.clock (clock), .reset (reset), .instr (instr), .state (state),
		.pc_write (pc_write), .ir_write (ir_write), .reg_write (reg_write),
		.alu_out_load (alu_out_load), .a_b_load (a_b_load), .xch_load (xch_load),
		.hi_lo_load (hi_lo_load), .mult_start (mult_start), .div_start (div_start),
		.shift_amt_from_rs (shift_amt_from_rs), .alu_op (alu_op), .alu_src_a (alu_src_a),
		.alu_src_b (alu_src_b), .pc_source (pc_source), .reg_dst (reg_dst),
		.mem_to_reg (mem_to_reg), .shift_op (shift_op)
	);

	// R format word with random register and shamt fields
	function automatic logic [31:0] r_word(input logic [5:0] funct);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {6'h00, rnd[25:6], funct};
	endfunction

	function automatic logic [31:0] j_word(input logic [5:0] opcode);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {opcode, rnd[25:0]};
	endfunction

	`include "tb_vectors.svh"

	task automatic check_value(input string what, input int got, input int expected);
		if (got !== expected) begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the control unit did not get back to fetch in time");
			$display("FAIL: see errors above");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic run_row(input int i);
		int    cycles, n_write, n_pc, n_ir, n_pc4, pre_pc, n_decode, exec_alu;
		int    first_dst, first_wb, last_dst, last_wb, run_shift, n_amt;
		int    n_mult, n_div, n_hilo, pc_src;
		bit    driven, left_fetch, done;
		logic [7:0] prev_state;
		{cycles, n_write, n_pc, n_ir, n_pc4, pre_pc, n_decode, n_amt} = '0;
		{n_mult, n_div, n_hilo, run_shift} = '0;
		{exec_alu, first_dst, first_wb, last_dst, last_wb, pc_src} = '1;    // all -1
		{driven, left_fetch, done} = '0;
		prev_state = 8'h00;
		while (!done) begin
			cycles++;
			if (ir_write) n_ir++;
			if (ir_write && alu_op == 3'd1 && alu_src_a == 2'd0 && alu_src_b == 3'd1) begin
				n_pc4++;    // pc + 4 while fetching
			end
			if (pc_write) begin
				n_pc++;
				pc_src = pc_source;
				if (state != 8'h03 && !left_fetch) pre_pc++;    // before decode
			end
			if (state == 8'h03 && a_b_load && xch_load && alu_out_load) n_decode++;
			if (prev_state == 8'h03) exec_alu = alu_op;
			if (reg_write) begin
				n_write++;
				if (first_dst < 0) begin
					first_dst = reg_dst;
					first_wb  = mem_to_reg;
				end
				last_dst = reg_dst;
				last_wb  = mem_to_reg;
			end
			if (state == 8'h86) run_shift = shift_op;
			if (shift_amt_from_rs) n_amt++;
			if (mult_start) n_mult++;
			if (div_start) n_div++;
			if (hi_lo_load) n_hilo++;
			prev_state = state;
			if (state == 8'h01 && n_ir == 2 && !driven) begin
				@(posedge clock);
				instr <= row_word[i];    // word ready as fetch_2 begins
				driven = 1'b1;
			end
			@(negedge clock);
			if (prev_state != 8'h01) left_fetch = 1'b1;
			if (state == 8'h01 && left_fetch) done = 1'b1;
		end
		check_value({row_name[i], " cycles"}, cycles, row_cycles[i]);
		check_value({row_name[i], " ir_write cycles"}, n_ir, 2);
		check_value({row_name[i], " fetch pc + 4 cycles"}, n_pc4, 2);
		check_value({row_name[i], " pc_write before decode"}, pre_pc, 1);
		check_value({row_name[i], " decode loads"}, n_decode, 1);
		check_value({row_name[i], " reg_write cycles"}, n_write, row_n_write[i]);
		check_value({row_name[i], " pc_write cycles"}, n_pc, row_n_pc[i]);
		check_value({row_name[i], " exec alu_op"}, exec_alu, row_exec_alu[i]);
		check_value({row_name[i], " first reg_dst"}, first_dst, row_first_dst[i]);
		check_value({row_name[i], " first mem_to_reg"}, first_wb, row_first_wb[i]);
		check_value({row_name[i], " last reg_dst"}, last_dst, row_last_dst[i]);
		check_value({row_name[i], " mem_to_reg"}, last_wb, row_last_wb[i]);
		check_value({row_name[i], " shift_op"}, run_shift, row_run_shift[i]);
		check_value({row_name[i], " shift_amt_from_rs"}, n_amt, row_n_amt[i]);
		check_value({row_name[i], " mult_start"}, n_mult, row_n_mult[i]);
		check_value({row_name[i], " div_start"}, n_div, row_n_div[i]);
		check_value({row_name[i], " hi_lo_load"}, n_hilo, row_n_hilo[i]);
		check_value({row_name[i], " pc_source"}, pc_src, row_pc_src[i]);
	endtask

	initial begin
		int total;
		reset = 1'b1;
		instr = '0;
		load_vectors();
		total = 0;
		for (int i = 0; i < NUM_ROWS; i++) total += row_cycles[i];
		cycle_limit = total + 20;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		// one reset cycle that loads sp
		check_value("reset state", state, 8'h00);
		check_value("reset reg_write", reg_write, 1);
		check_value("reset reg_dst", reg_dst, 3);
		check_value("reset mem_to_reg", mem_to_reg, 7);
		check_value("reset other enables",
			{pc_write, ir_write, alu_out_load, a_b_load, xch_load, hi_lo_load,
			 mult_start, div_start}, 0);
		@(negedge clock);
		check_value("state after reset", state, 8'h01);
		for (int i = 0; i < NUM_ROWS; i++) run_row(i);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: src.f
+incdir+test
common/mips_isa_pkg.sv
common/ctrl_pkg.sv
src/instr_decoder.sv
control_fsm/state_sequencer.sv
control_fsm/datapath_ctrl_gen.sv
src/multicycle_control.sv
test/tb_multicycle_control.sv

// File: Bender.yml
package:
  name: multicycle_control

sources:
  - common/mips_isa_pkg.sv
  - common/ctrl_pkg.sv
  - src/instr_decoder.sv
  - control_fsm/state_sequencer.sv
  - control_fsm/datapath_ctrl_gen.sv
  - src/multicycle_control.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_multicycle_control.sv
